// ==== sparse_cluster_defines.svh ====
`ifndef SPARSE_CLUSTER_DEFINES_SVH
`define SPARSE_CLUSTER_DEFINES_SVH

//////////////////////////////
// Write bus and chunk sizing
//////////////////////////////

// Sparsemap bits and byte lanes per write beat
`define BUS_SIZE 8

// Elements held by one chunk
`define MEM_SIZE 32

// Sparsemap bits per read segment equal the bus width
`define PREFIX_SUM_SIZE 8

//////////////////////////////
// Cluster and output sizing
//////////////////////////////

`define COMPUTE_UNIT_NUM 4
`define OUTPUT_BUF_NUM 4

// Accumulator width
`define OUTPUT_BUF_SIZE 24

`endif

// ==== sparse_cluster_pkg.sv ====
`include "sparse_cluster_defines.svh"

package sparse_cluster_pkg;

	// One beat of sparsemap or one read segment
	typedef logic [`BUS_SIZE-1:0] sparsemap_beat_t;

	// Packed nonzero bytes of one beat with lane 0 first
	typedef logic [`BUS_SIZE-1:0][7:0] data_beat_t;

	typedef logic signed [7:0] elem_t;

	typedef logic [$clog2(`MEM_SIZE/`BUS_SIZE)-1:0] beat_idx_t;

	// Wide enough to hold a full chunk of segments
	typedef logic [$clog2(`MEM_SIZE/`BUS_SIZE):0] seg_cnt_t;

	typedef logic [$clog2(`COMPUTE_UNIT_NUM)-1:0] unit_idx_t;
	typedef logic [$clog2(`OUTPUT_BUF_NUM)-1:0] obuf_idx_t;

	typedef logic signed [`OUTPUT_BUF_SIZE-1:0] acc_t;

	// One write beat into a chunk buffer
	typedef struct packed {
		logic valid;
		beat_idx_t beat_idx;
		sparsemap_beat_t sparsemap;
		data_beat_t data;
		logic bank_sel;
	} chunk_wr_t;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		DRAIN,
		DONE
	} mac_state_e;

endpackage

// ==== sparse_chunk_buf.sv ====
`timescale 1ns/1ps
`include "sparse_cluster_defines.svh"

module sparse_chunk_buf import sparse_cluster_pkg::*; #(
	 localparam BEAT_NUM = `MEM_SIZE/`BUS_SIZE
	,localparam ADDR_W = $clog2(`MEM_SIZE)
	,localparam LANE_W = $clog2(`BUS_SIZE)
)(
	 input logic clk_i
	,input logic reset_i

	,input chunk_wr_t wr_i

	,input logic rd_sel_i
	,input beat_idx_t rd_seg_i
	,input logic [ADDR_W-1:0] rd_addr_i

	,output sparsemap_beat_t rd_sparsemap_o
	,output elem_t rd_data_o
);

	// Two banks, one beat of sparsemap per entry
	sparsemap_beat_t smap_q [2][BEAT_NUM];

	// Two banks of packed nonzero bytes
	elem_t data_q [2][`MEM_SIZE];

	//////////////////////////////
	// Write side
	//////////////////////////////

	// Cleared so an unwritten chunk gives no matches
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int b = 0; b < 2; b++) begin
				for (int s = 0; s < BEAT_NUM; s++) begin
					smap_q[b][s] <= '0;
				end
			end
		end else if (wr_i.valid) begin
			smap_q[wr_i.bank_sel][wr_i.beat_idx] <= wr_i.sparsemap;
		end
	end

	// Byte lanes land at the beat base address
	always_ff @(posedge clk_i) begin
		if (wr_i.valid) begin
			for (int l = 0; l < `BUS_SIZE; l++) begin
				data_q[wr_i.bank_sel][{wr_i.beat_idx, LANE_W'(l)}] <= wr_i.data[l];
			end
		end
	end

	//////////////////////////////
	// Read side
	//////////////////////////////

	// Segment k is beat k since both widths match
	assign rd_sparsemap_o = smap_q[rd_sel_i][rd_seg_i];

	assign rd_data_o = data_q[rd_sel_i][rd_addr_i];

endmodule

// ==== sparse_mac_engine.sv ====
`timescale 1ns/1ps
`include "sparse_cluster_defines.svh"

module sparse_mac_engine import sparse_cluster_pkg::*; #(
	 localparam ADDR_W = $clog2(`MEM_SIZE)
	,localparam LANE_W = $clog2(`PREFIX_SUM_SIZE)
)(
	 input logic clk_i
	,input logic reset_i

	,input logic run_valid_i
	,input logic chunk_start_i
	,input seg_cnt_t rd_sparsemap_num_i
	,input obuf_idx_t acc_buf_sel_i
	,input obuf_idx_t out_buf_sel_i

	,input sparsemap_beat_t ifm_sparsemap_i
	,input sparsemap_beat_t filter_sparsemap_i
	,input elem_t ifm_data_i
	,input elem_t filter_data_i

	,output beat_idx_t rd_seg_o
	,output logic [ADDR_W-1:0] ifm_rd_addr_o
	,output logic [ADDR_W-1:0] filter_rd_addr_o
	,output logic chunk_end_o
	,output acc_t out_buf_dat_o
);

	mac_state_e state_q;
	beat_idx_t seg_q;
	seg_cnt_t seg_num_q;
	obuf_idx_t acc_sel_q;
	sparsemap_beat_t mask_q;
	logic mask_ld_q;
	logic chunk_end_q;

	sparsemap_beat_t cur_mask;
	sparsemap_beat_t pick;
	sparsemap_beat_t mask_nxt;
	logic seg_done;
	logic last_seg;
	logic issue;
	logic [LANE_W-1:0] ifm_lane;
	logic [LANE_W-1:0] filter_lane;

	// Pipeline
	logic op_vld_q;
	logic prod_vld_q;
	elem_t ifm_op_q;
	elem_t filter_op_q;
	logic signed [15:0] prod_q;

	acc_t obuf_q [`OUTPUT_BUF_NUM];

	// Prefix sum of the map bits below the picked position
	function automatic logic [LANE_W-1:0] bits_below(
		input sparsemap_beat_t map,
		input sparsemap_beat_t sel
	);
		logic [LANE_W-1:0] cnt;
		logic found;
		cnt = '0;
		found = 1'b0;
		for (int i = 0; i < `PREFIX_SUM_SIZE; i++) begin
			if (sel[i]) begin
				found = 1'b1;
			end else if (!found && map[i]) begin
				cnt = cnt + 1'b1;
			end
		end
		return cnt;
	endfunction

	//////////////////////////////
	// Match selection
	//////////////////////////////

	// Fresh segment takes the AND straight from the buffers
	assign cur_mask = mask_ld_q ? mask_q : (ifm_sparsemap_i & filter_sparsemap_i);

	// Lowest set bit
	assign pick = cur_mask & (~cur_mask + 1'b1);
	assign mask_nxt = cur_mask & ~pick;
	assign seg_done = (mask_nxt == '0);
	assign last_seg = ({1'b0, seg_q} + seg_cnt_t'(1)) >= seg_num_q;
	assign issue = (state_q == SCAN) && (cur_mask != '0);

	assign ifm_lane = bits_below(ifm_sparsemap_i, pick);
	assign filter_lane = bits_below(filter_sparsemap_i, pick);

	assign rd_seg_o = seg_q;
	assign ifm_rd_addr_o = {seg_q, ifm_lane};
	assign filter_rd_addr_o = {seg_q, filter_lane};

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			seg_q <= '0;
			seg_num_q <= '0;
			acc_sel_q <= '0;
			mask_q <= '0;
			mask_ld_q <= 1'b0;
			chunk_end_q <= 1'b0;
		end else if (chunk_start_i) begin
			state_q <= SCAN;
			seg_q <= '0;
			seg_num_q <= rd_sparsemap_num_i;
			acc_sel_q <= acc_buf_sel_i;
			mask_ld_q <= 1'b0;
			chunk_end_q <= 1'b0;
		end else if (run_valid_i) begin
			case (state_q)
				SCAN: begin
					if (seg_done) begin
						mask_ld_q <= 1'b0;
						if (last_seg) begin
							state_q <= DRAIN;
						end else begin
							seg_q <= seg_q + 1'b1;
						end
					end else begin
						mask_q <= mask_nxt;
						mask_ld_q <= 1'b1;
					end
				end
				// Last product is added on the same edge
				DRAIN: begin
					if (!op_vld_q) begin
						state_q <= DONE;
						chunk_end_q <= 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign chunk_end_o = chunk_end_q;

	//////////////////////////////
	// Multiply and accumulate
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			op_vld_q <= 1'b0;
			prod_vld_q <= 1'b0;
		end else if (run_valid_i) begin
			op_vld_q <= issue;
			prod_vld_q <= op_vld_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (run_valid_i) begin
			if (issue) begin
				ifm_op_q <= ifm_data_i;
				filter_op_q <= filter_data_i;
			end
			if (op_vld_q) begin
				prod_q <= ifm_op_q * filter_op_q;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int b = 0; b < `OUTPUT_BUF_NUM; b++) begin
				obuf_q[b] <= '0;
			end
		end else if (run_valid_i && prod_vld_q) begin
			obuf_q[acc_sel_q] <= obuf_q[acc_sel_q] + acc_t'(prod_q);
		end
	end

	assign out_buf_dat_o = obuf_q[out_buf_sel_i];

endmodule

// ==== compute_unit_top.sv ====
`timescale 1ns/1ps
`include "sparse_cluster_defines.svh"

module compute_unit_top import sparse_cluster_pkg::*; #(
	 localparam ADDR_W = $clog2(`MEM_SIZE)
)(
	 input logic clk_i
	,input logic reset_i

	,input chunk_wr_t ifm_wr_i
	,input chunk_wr_t filter_wr_i
	,input logic ifm_rd_sel_i
	,input logic filter_rd_sel_i

	,input logic run_valid_i
	,input logic chunk_start_i
	,input seg_cnt_t rd_sparsemap_num_i
	,input obuf_idx_t acc_buf_sel_i
	,input obuf_idx_t out_buf_sel_i

	,output logic chunk_end_o
	,output acc_t out_buf_dat_o
);

	// Read paths between buffers and engine
	beat_idx_t rd_seg;
	logic [ADDR_W-1:0] ifm_rd_addr;
	logic [ADDR_W-1:0] filter_rd_addr;
	sparsemap_beat_t ifm_sparsemap;
	sparsemap_beat_t filter_sparsemap;
	elem_t ifm_data;
	elem_t filter_data;

	sparse_chunk_buf u_ifm_buf (
		 .clk_i
		,.reset_i
		,.wr_i(ifm_wr_i)
		,.rd_sel_i(ifm_rd_sel_i)
		,.rd_seg_i(rd_seg)
		,.rd_addr_i(ifm_rd_addr)
		,.rd_sparsemap_o(ifm_sparsemap)
		,.rd_data_o(ifm_data)
	);

	sparse_chunk_buf u_filter_buf (
		 .clk_i
		,.reset_i
		,.wr_i(filter_wr_i)
		,.rd_sel_i(filter_rd_sel_i)
		,.rd_seg_i(rd_seg)
		,.rd_addr_i(filter_rd_addr)
		,.rd_sparsemap_o(filter_sparsemap)
		,.rd_data_o(filter_data)
	);

	sparse_mac_engine u_mac_engine (
		 .clk_i
		,.reset_i
		,.run_valid_i
		,.chunk_start_i
		,.rd_sparsemap_num_i
		,.acc_buf_sel_i
		,.out_buf_sel_i
		,.ifm_sparsemap_i(ifm_sparsemap)
		,.filter_sparsemap_i(filter_sparsemap)
		,.ifm_data_i(ifm_data)
		,.filter_data_i(filter_data)
		,.rd_seg_o(rd_seg)
		,.ifm_rd_addr_o(ifm_rd_addr)
		,.filter_rd_addr_o(filter_rd_addr)
		,.chunk_end_o
		,.out_buf_dat_o
	);

endmodule

// ==== compute_cluster.sv ====
`timescale 1ns/1ps
`include "sparse_cluster_defines.svh"

module compute_cluster import sparse_cluster_pkg::*; (
	 input logic clk_i
	,input logic reset_i

	,input chunk_wr_t ifm_wr_i
	,input chunk_wr_t filter_wr_i
	,input unit_idx_t filter_wr_order_sel_i
	,input logic ifm_rd_sel_i
	,input logic filter_rd_sel_i

	,input logic run_valid_i
	,input logic chunk_start_i
	,input seg_cnt_t rd_sparsemap_num_i
	,input obuf_idx_t acc_buf_sel_i

	,input obuf_idx_t out_buf_sel_i
	,input unit_idx_t com_unit_out_buf_sel_i

	,output logic total_chunk_end_o
	,output acc_t out_buf_dat_o
);

	chunk_wr_t filter_wr_w [`COMPUTE_UNIT_NUM];
	logic [`COMPUTE_UNIT_NUM-1:0] chunk_end_w;
	acc_t out_buf_dat_w [`COMPUTE_UNIT_NUM];

	//////////////////////////////
	// Filter write steering
	//////////////////////////////

	// Only the selected unit sees the valid
	always_comb begin
		for (int i = 0; i < `COMPUTE_UNIT_NUM; i++) begin
			filter_wr_w[i] = filter_wr_i;
			filter_wr_w[i].valid = filter_wr_i.valid && (filter_wr_order_sel_i == unit_idx_t'(i));
		end
	end

	for (genvar i = 0; i < `COMPUTE_UNIT_NUM; i++) begin : gen_com_unit
		compute_unit_top u_compute_unit_top (
			 .clk_i
			,.reset_i
			,.ifm_wr_i
			,.filter_wr_i(filter_wr_w[i])
			,.ifm_rd_sel_i
			,.filter_rd_sel_i
			,.run_valid_i
			,.chunk_start_i
			,.rd_sparsemap_num_i
			,.acc_buf_sel_i
			,.out_buf_sel_i
			,.chunk_end_o(chunk_end_w[i])
			,.out_buf_dat_o(out_buf_dat_w[i])
		);
	end

	// Done only when every unit is done
	assign total_chunk_end_o = &chunk_end_w;

	assign out_buf_dat_o = out_buf_dat_w[com_unit_out_buf_sel_i];

endmodule

// ==== tb_compute_cluster.sv ====
`timescale 1ns/1ps
`include "sparse_cluster_defines.svh"

module tb_compute_cluster import sparse_cluster_pkg::*; ();

	localparam int UNITS = `COMPUTE_UNIT_NUM;
	localparam int BUFS = `OUTPUT_BUF_NUM;
	localparam int BEATS = `MEM_SIZE/`BUS_SIZE;
	localparam int LANES = `BUS_SIZE;
	localparam int RUN_TIMEOUT = 400;

	logic clk;
	logic reset;
	chunk_wr_t ifm_wr;
	chunk_wr_t filter_wr;
	unit_idx_t filter_sel;
	logic ifm_rd_sel;
	logic filter_rd_sel;
	logic run_valid;
	logic chunk_start;
	seg_cnt_t seg_num;
	obuf_idx_t acc_sel;
	obuf_idx_t out_sel;
	unit_idx_t unit_sel;
	logic total_end;
	acc_t out_dat;

	// Model copies of both banks and of every output buffer
	sparsemap_beat_t ifm_map [2][BEATS];
	elem_t ifm_val [2][BEATS][LANES];
	sparsemap_beat_t flt_map [UNITS][2][BEATS];
	elem_t flt_val [UNITS][2][BEATS][LANES];
	longint model_buf [UNITS][BUFS];

	logic [31:0] lfsr_q;
	int checks;
	int errors;
	int timeouts;

	compute_cluster DUT (
		 .clk_i(clk)
		,.reset_i(reset)
		,.ifm_wr_i(ifm_wr)
		,.filter_wr_i(filter_wr)
		,.filter_wr_order_sel_i(filter_sel)
		,.ifm_rd_sel_i(ifm_rd_sel)
		,.filter_rd_sel_i(filter_rd_sel)
		,.run_valid_i(run_valid)
		,.chunk_start_i(chunk_start)
		,.rd_sparsemap_num_i(seg_num)
		,.acc_buf_sel_i(acc_sel)
		,.out_buf_sel_i(out_sel)
		,.com_unit_out_buf_sel_i(unit_sel)
		,.total_chunk_end_o(total_end)
		,.out_buf_dat_o(out_dat)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// Random source and model
	//////////////////////////////

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_bit()};
		end
		return r;
	endfunction

	// Lane of a nonzero element is the number of set bits below it
	function automatic int count_below(input sparsemap_beat_t map, input int pos);
		int n;
		n = 0;
		for (int i = 0; i < pos; i++) begin
			n += map[i];
		end
		return n;
	endfunction

	function automatic longint dot_model(input int u, input int ib, input int fb, input int nseg);
		longint sum;
		sum = 0;
		for (int s = 0; s < nseg; s++) begin
			for (int p = 0; p < LANES; p++) begin
				if (ifm_map[ib][s][p] && flt_map[u][fb][s][p]) begin
					sum += longint'(ifm_val[ib][s][count_below(ifm_map[ib][s], p)])
						* longint'(flt_val[u][fb][s][count_below(flt_map[u][fb][s], p)]);
				end
			end
		end
		return sum;
	endfunction

	// Negative unit means the IFM chunk
	function automatic chunk_wr_t make_beat(input int bank, input int s, input int u);
		chunk_wr_t w;
		w.valid = 1'b1;
		w.beat_idx = beat_idx_t'(s);
		w.bank_sel = bank[0];
		w.sparsemap = (u < 0) ? ifm_map[bank][s] : flt_map[u][bank][s];
		for (int l = 0; l < LANES; l++) begin
			w.data[l] = (u < 0) ? ifm_val[bank][s][l] : flt_val[u][bank][s][l];
		end
		return w;
	endfunction

	task automatic fill_bank(input int bank, input bit dense);
		for (int s = 0; s < BEATS; s++) begin
			ifm_map[bank][s] = dense ? 8'hff : sparsemap_beat_t'(rand_bits(8));
			for (int l = 0; l < LANES; l++) begin
				ifm_val[bank][s][l] = elem_t'(rand_bits(8));
			end
			for (int u = 0; u < UNITS; u++) begin
				flt_map[u][bank][s] = dense ? 8'hff : sparsemap_beat_t'(rand_bits(8));
				for (int l = 0; l < LANES; l++) begin
					flt_val[u][bank][s][l] = elem_t'(rand_bits(8));
				end
			end
		end
	endtask

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int u = 0; u < UNITS; u++) begin
			for (int b = 0; b < BUFS; b++) begin
				model_buf[u][b] = 0;
			end
		end
	endtask

	task automatic load_bank(input int bank);
		for (int s = 0; s < BEATS; s++) begin
			@(posedge clk);
			#2;
			ifm_wr = make_beat(bank, s, -1);
		end
		for (int u = 0; u < UNITS; u++) begin
			for (int s = 0; s < BEATS; s++) begin
				@(posedge clk);
				#2;
				ifm_wr.valid = 1'b0;
				filter_sel = unit_idx_t'(u);
				filter_wr = make_beat(bank, s, u);
			end
		end
		@(posedge clk);
		#2;
		filter_wr.valid = 1'b0;
	endtask

	task automatic run_chunk(input int nseg, input int buf_idx, input bit stall);
		int cycles;
		for (int u = 0; u < UNITS; u++) begin
			model_buf[u][buf_idx] += dot_model(u, ifm_rd_sel, filter_rd_sel, nseg);
		end
		@(posedge clk);
		#2;
		seg_num = seg_cnt_t'(nseg);
		acc_sel = obuf_idx_t'(buf_idx);
		chunk_start = 1'b1;
		@(posedge clk);
		#2;
		chunk_start = 1'b0;
		cycles = 0;
		while (total_end !== 1'b1 && cycles < RUN_TIMEOUT) begin
			if (stall) begin
				run_valid = (rand_bits(2) != 0);
			end
			@(posedge clk);
			#2;
			cycles++;
		end
		run_valid = 1'b1;
		if (total_end !== 1'b1) begin
			timeouts++;
			$display("Timeout: total chunk end did not rise within %0d cycles", RUN_TIMEOUT);
		end
	endtask

	task automatic check_buffers(input string tag);
		for (int u = 0; u < UNITS; u++) begin
			for (int b = 0; b < BUFS; b++) begin
				@(posedge clk);
				#2;
				unit_sel = unit_idx_t'(u);
				out_sel = obuf_idx_t'(b);
				#1;
				checks++;
				assert (out_dat === acc_t'(model_buf[u][b])) else begin
					errors++;
					$display("[FAIL] %0t ns: %s unit %0d buffer %0d read %0d, expected %0d",
						$time, tag, u, b, out_dat, acc_t'(model_buf[u][b]));
				end
			end
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic check_reset_state();
		checks++;
		assert (total_end === 1'b0) else begin
			errors++;
			$display("[FAIL] %0t ns: total chunk end is high after reset", $time);
		end
		check_buffers("reset");
	endtask

	// Full chunk with a separate filter for every unit
	task automatic dense_chunk();
		fill_bank(0, 1'b1);
		load_bank(0);
		run_chunk(BEATS, 0, 1'b0);
		check_buffers("dense");
	endtask

	task automatic random_sparse_chunks();
		int nseg;
		int buf_idx;
		for (int i = 0; i < 6; i++) begin
			fill_bank(0, 1'b0);
			// First pass gives the last unit no matches at all
			if (i == 0) begin
				for (int s = 0; s < BEATS; s++) begin
					flt_map[UNITS-1][0][s] = '0;
				end
			end
			load_bank(0);
			nseg = int'(rand_bits(2)) + 1;
			buf_idx = int'(rand_bits(2));
			run_chunk(nseg, buf_idx, 1'b0);
			check_buffers("sparse");
		end
	endtask

	task automatic accumulate_chunks();
		@(posedge clk);
		#2;
		apply_reset();
		for (int i = 0; i < 3; i++) begin
			fill_bank(0, 1'b0);
			load_bank(0);
			run_chunk(BEATS, (i < 2) ? 1 : 2, 1'b0);
			check_buffers("accumulate");
		end
	endtask

	// Bank 1 fills while bank 0 is being read
	task automatic swap_banks();
		fill_bank(0, 1'b0);
		fill_bank(1, 1'b0);
		load_bank(0);
		fork
			run_chunk(BEATS, 3, 1'b0);
			load_bank(1);
		join
		check_buffers("bank 0");
		@(posedge clk);
		#2;
		ifm_rd_sel = 1'b1;
		filter_rd_sel = 1'b1;
		run_chunk(BEATS, 3, 1'b0);
		check_buffers("bank 1");
	endtask

	task automatic stalled_runs();
		@(posedge clk);
		#2;
		ifm_rd_sel = 1'b0;
		filter_rd_sel = 1'b0;
		for (int i = 0; i < 3; i++) begin
			fill_bank(0, 1'b0);
			load_bank(0);
			run_chunk(BEATS, i, 1'b1);
			check_buffers("stall");
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ifm_wr = '0;
		filter_wr = '0;
		filter_sel = '0;
		ifm_rd_sel = 1'b0;
		filter_rd_sel = 1'b0;
		run_valid = 1'b0;
		chunk_start = 1'b0;
		seg_num = '0;
		acc_sel = '0;
		out_sel = '0;
		unit_sel = '0;
		lfsr_q = 32'hd1c9;
		checks = 0;
		errors = 0;
		timeouts = 0;

		apply_reset();
		run_valid = 1'b1;
		check_reset_state();
		dense_chunk();
		random_sparse_chunks();
		accumulate_chunks();
		swap_banks();
		stalled_runs();

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== sparse_cluster.f ====
+incdir+.
sparse_cluster_pkg.sv
sparse_chunk_buf.sv
sparse_mac_engine.sv
compute_unit_top.sv
compute_cluster.sv
tb_compute_cluster.sv

// ==== Bender.yml ====
package:
  name: sparse_cluster

sources:
  - include_dirs:
      - .
    files:
      - sparse_cluster_pkg.sv
      - sparse_chunk_buf.sv
      - sparse_mac_engine.sv
      - compute_unit_top.sv
      - compute_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_compute_cluster.sv
